// ==== hdl/pit_config.svh ====
/*
 * Interval timer configuration macros
 *   count and bus widths
 *   control word field positions
 *   register addresses on the one-bit address
 */
`ifndef PIT_CONFIG_SVH
`define PIT_CONFIG_SVH

// Preset width; internal count is one bit wider to hold 65536
`define PIT_COUNT_WIDTH 16
`define PIT_BYTE_WIDTH 8

`define PIT_ADDR_COUNTER 1'b0
`define PIT_ADDR_CONTROL 1'b1

// Control word fields
`define PIT_RW_LSB 4
`define PIT_RW_MSB 5
`define PIT_MODE_LSB 1
`define PIT_MODE_MSB 3

`endif

// ==== hdl/pit_pkg.sv ====
/*
 * Shared interval timer types
 *   rw_format_t   control word read/load field
 *   count_mode_t  decoded counting mode
 */
`default_nettype none

`include "pit_config.svh"

package pit_pkg;

    // Encoding matches the control word read/load field
    typedef enum logic [`PIT_RW_MSB-`PIT_RW_LSB:0] {
        RW_LATCH    = 2'd0,
        RW_MSB_ONLY = 2'd1,
        RW_LSB_ONLY = 2'd2,
        RW_LSB_MSB  = 2'd3
    } rw_format_t;

    typedef enum logic {
        MODE_TERMINAL_COUNT = 1'b0,
        MODE_RATE_GENERATOR = 1'b1
    } count_mode_t;

endpackage

`default_nettype wire

// ==== hdl/pit_control_word.sv ====
/*
 * Timer register front end
 *   address decode of count and control registers
 *   control word storage, format and mode
 *   preset write byte sequencing
 *   read falling edge detection
 */
`default_nettype none

`include "pit_config.svh"

module pit_control_word (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       address,
    input  wire logic                       write,
    input  wire logic                       read,
    input  wire logic [`PIT_BYTE_WIDTH-1:0] data_in,
    output logic                            config_update,
    output pit_pkg::rw_format_t             rw_format,
    output pit_pkg::count_mode_t            count_mode,
    output logic                            preset_write_low,
    output logic                            preset_write_high,
    output logic                            preset_complete,
    output logic                            latch_command,
    output logic                            read_done
);

    logic                                  control_write;
    logic                                  counter_write;
    pit_pkg::rw_format_t                   rw_field;
    logic [`PIT_MODE_MSB-`PIT_MODE_LSB:0]  mode_field;
    logic                                  write_second;
    logic                                  write_low;
    logic                                  read_prev;

    assign control_write = write && (address == `PIT_ADDR_CONTROL);
    assign counter_write = write && (address == `PIT_ADDR_COUNTER);

    assign rw_field   = pit_pkg::rw_format_t'(data_in[`PIT_RW_MSB:`PIT_RW_LSB]);
    assign mode_field = data_in[`PIT_MODE_MSB:`PIT_MODE_LSB];

    // Latch command leaves format and mode untouched
    assign latch_command = control_write && (rw_field == pit_pkg::RW_LATCH);
    assign config_update = control_write && (rw_field != pit_pkg::RW_LATCH);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rw_format  <= pit_pkg::RW_MSB_ONLY;
            count_mode <= pit_pkg::MODE_TERMINAL_COUNT;
        end else if (config_update) begin
            rw_format <= rw_field;
            // Modes 2 and 6 both mean rate generator
            if (mode_field == 3'd2 || mode_field == 3'd6) begin
                count_mode <= pit_pkg::MODE_RATE_GENERATOR;
            end else begin
                count_mode <= pit_pkg::MODE_TERMINAL_COUNT;
            end
        end
    end

    // Set once the low byte of an LSB then MSB preset is in
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_second <= 1'b0;
        end else if (config_update) begin
            write_second <= 1'b0;
        end else if (counter_write && rw_format == pit_pkg::RW_LSB_MSB) begin
            write_second <= ~write_second;
        end
    end

    assign write_low = (rw_format == pit_pkg::RW_LSB_ONLY) ||
                       (rw_format == pit_pkg::RW_LSB_MSB && !write_second);

    assign preset_write_low  = counter_write && write_low;
    assign preset_write_high = counter_write && !write_low;

    // Last byte of the preset in the current format
    assign preset_complete = counter_write &&
                             (rw_format != pit_pkg::RW_LSB_MSB || write_second);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_prev <= 1'b0;
            read_done <= 1'b0;
        end else begin
            read_prev <= read;
            read_done <= read_prev && !read && (address == `PIT_ADDR_COUNTER);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pit_count_core.sv ====
/*
 * Timer counting core
 *   counter clock falling edge detection
 *   preset register, zero meaning 65536
 *   down-counter for terminal count and rate generator modes
 *   counter output waveform
 */
`default_nettype none

`include "pit_config.svh"

module pit_count_core (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic [`PIT_BYTE_WIDTH-1:0]  data_in,
    input  wire logic                        config_update,
    input  wire pit_pkg::count_mode_t        count_mode,
    input  wire logic                        preset_write_low,
    input  wire logic                        preset_write_high,
    input  wire logic                        preset_complete,
    input  wire logic                        counter_clock,
    input  wire logic                        counter_gate,
    output logic [`PIT_COUNT_WIDTH:0]        count,
    output logic                             counter_out
);

    localparam logic [`PIT_COUNT_WIDTH:0] COUNT_ONE = 1;

    logic [`PIT_COUNT_WIDTH-1:0]  preset;
    logic [`PIT_COUNT_WIDTH:0]    preset_value;
    logic                         clock_sample;
    logic                         count_edge;
    logic                         load_pending;
    logic                         counting;
    logic                         rate_mode;
    logic [`PIT_COUNT_WIDTH:0]    count_next;

    assign rate_mode = (count_mode == pit_pkg::MODE_RATE_GENERATOR);

    // A new control word clears both bytes, so single byte formats
    // leave the other byte at zero
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            preset <= '0;
        end else if (config_update) begin
            preset <= '0;
        end else begin
            if (preset_write_low) begin
                preset[`PIT_BYTE_WIDTH-1:0] <= data_in;
            end
            if (preset_write_high) begin
                preset[`PIT_COUNT_WIDTH-1:`PIT_BYTE_WIDTH] <= data_in;
            end
        end
    end

    assign preset_value = (preset == '0) ? {1'b1, {`PIT_COUNT_WIDTH{1'b0}}}
                                         : {1'b0, preset};

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            clock_sample <= 1'b0;
        end else begin
            clock_sample <= counter_clock;
        end
    end

    assign count_edge = clock_sample && !counter_clock;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            load_pending <= 1'b0;
            counting     <= 1'b0;
        end else if (config_update) begin
            load_pending <= 1'b0;
            counting     <= 1'b0;
        end else begin
            if (preset_complete) begin
                load_pending <= 1'b1;
            end else if (count_edge) begin
                load_pending <= 1'b0;
            end
            if (count_edge && load_pending) begin
                counting <= 1'b1;
            end
        end
    end

    always_comb begin
        count_next = count;
        if (load_pending) begin
            count_next = preset_value;
        end else if (counter_gate) begin
            if (rate_mode) begin
                count_next = count - COUNT_ONE;
                // Reload instead of reaching zero
                if (count_next == '0) begin
                    count_next = preset_value;
                end
            end else if (count != '0) begin
                count_next = count - COUNT_ONE;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (config_update) begin
            count <= '0;
        end else if (count_edge && (counting || load_pending)) begin
            count <= count_next;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            counter_out <= 1'b0;
        end else if (config_update || !counting) begin
            // Idle level, low for mode 0 and high for mode 2
            counter_out <= rate_mode;
        end else if (rate_mode && !counter_gate) begin
            counter_out <= 1'b1;
        end else if (!rate_mode && preset_complete) begin
            counter_out <= 1'b0;
        end else if (count_edge) begin
            if (rate_mode) begin
                counter_out <= (count_next != COUNT_ONE);
            end else begin
                counter_out <= (count_next == '0);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pit_read_latch.sv ====
/*
 * Count readback
 *   counter latch command handling
 *   read byte sequencing
 *   data_out byte select
 */
`default_nettype none

`include "pit_config.svh"

module pit_read_latch (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic [`PIT_COUNT_WIDTH:0]  count,
    input  wire pit_pkg::rw_format_t        rw_format,
    input  wire logic                       config_update,
    input  wire logic                       latch_command,
    input  wire logic                       read_done,
    output logic [`PIT_BYTE_WIDTH-1:0]      data_out
);

    logic [`PIT_COUNT_WIDTH-1:0]  held_value;
    logic                         latch_held;
    logic                         read_second;
    logic                         read_low;

    // A count of 65536 reads back as zero
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            held_value <= '0;
        end else if (!latch_held) begin
            held_value <= count[`PIT_COUNT_WIDTH-1:0];
        end
    end

    // Further latch commands are ignored until the held value is read
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            latch_held <= 1'b0;
        end else if (latch_command) begin
            latch_held <= 1'b1;
        end else if (read_done && (rw_format != pit_pkg::RW_LSB_MSB || read_second)) begin
            latch_held <= 1'b0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_second <= 1'b0;
        end else if (config_update) begin
            read_second <= 1'b0;
        end else if (read_done && rw_format == pit_pkg::RW_LSB_MSB) begin
            read_second <= ~read_second;
        end
    end

    assign read_low = (rw_format == pit_pkg::RW_LSB_ONLY) ||
                      (rw_format == pit_pkg::RW_LSB_MSB && !read_second);

    assign data_out = read_low ? held_value[`PIT_BYTE_WIDTH-1:0]
                               : held_value[`PIT_COUNT_WIDTH-1:`PIT_BYTE_WIDTH];

endmodule

`default_nettype wire

// ==== hdl/pit_counter.sv ====
/*
 * Programmable interval timer, single channel
 *   register front end, counting core and readback
 */
`default_nettype none

`include "pit_config.svh"

module pit_counter (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       address,
    input  wire logic                       write,
    input  wire logic                       read,
    input  wire logic [`PIT_BYTE_WIDTH-1:0] data_in,
    input  wire logic                       counter_clock,
    input  wire logic                       counter_gate,
    output logic      [`PIT_BYTE_WIDTH-1:0] data_out,
    output logic                            counter_out
);

    logic                       config_update;
    pit_pkg::rw_format_t        rw_format;
    pit_pkg::count_mode_t       count_mode;
    logic                       preset_write_low;
    logic                       preset_write_high;
    logic                       preset_complete;
    logic                       latch_command;
    logic                       read_done;
    logic [`PIT_COUNT_WIDTH:0]  count;

    pit_control_word control_word0 (
        .clock             (clock),
        .reset             (reset),
        .address           (address),
        .write             (write),
        .read              (read),
        .data_in           (data_in),
        .config_update     (config_update),
        .rw_format         (rw_format),
        .count_mode        (count_mode),
        .preset_write_low  (preset_write_low),
        .preset_write_high (preset_write_high),
        .preset_complete   (preset_complete),
        .latch_command     (latch_command),
        .read_done         (read_done)
    );

    pit_count_core count_core0 (
        .clock             (clock),
        .reset             (reset),
        .data_in           (data_in),
        .config_update     (config_update),
        .count_mode        (count_mode),
        .preset_write_low  (preset_write_low),
        .preset_write_high (preset_write_high),
        .preset_complete   (preset_complete),
        .counter_clock     (counter_clock),
        .counter_gate      (counter_gate),
        .count             (count),
        .counter_out       (counter_out)
    );

    pit_read_latch read_latch0 (
        .clock         (clock),
        .reset         (reset),
        .count         (count),
        .rw_format     (rw_format),
        .config_update (config_update),
        .latch_command (latch_command),
        .read_done     (read_done),
        .data_out      (data_out)
    );

endmodule

`default_nettype wire

// ==== dv/pit_counter_sva.sv ====
/*
 * Interval timer assertions, bound to the top level
 *   counter_out changes only after an event
 *   rate generator output high while gate is low
 */
`default_nettype none

module pit_counter_sva (
    input wire logic                 clock,
    input wire logic                 reset,
    input wire logic                 write,
    input wire logic                 counter_clock,
    input wire logic                 counter_gate,
    input wire logic                 counter_out,
    input wire pit_pkg::count_mode_t count_mode
);

    logic clock_prev;
    logic cause;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            clock_prev <= 1'b0;
        end else begin
            clock_prev <= counter_clock;
        end
    end

    // Counter clock falling edge, a bus write or a low gate in rate generator mode
    assign cause = (clock_prev && !counter_clock) || write ||
                   (count_mode == pit_pkg::MODE_RATE_GENERATOR && !counter_gate);

    out_change_has_cause: assert property (@(posedge clock) disable iff (reset)
        $changed(counter_out) |-> ($past(cause) || $past(write, 2)))
        else $error("counter_out changed without a counter clock edge or write");

    rate_gate_low_high: assert property (@(posedge clock) disable iff (reset)
        (count_mode == pit_pkg::MODE_RATE_GENERATOR && !counter_gate) |=> counter_out)
        else $error("counter_out low while gate low in rate generator mode");

endmodule

bind pit_counter pit_counter_sva sva0 (
    .clock         (clock),
    .reset         (reset),
    .write         (write),
    .counter_clock (counter_clock),
    .counter_gate  (counter_gate),
    .counter_out   (counter_out),
    .count_mode    (count_mode)
);

`default_nettype wire

// ==== dv/pit_counter_checker.sv ====
/*
 * Interval timer checker
 *   samples counter_out and data_out on request
 *   per test result lines and closing counts
 */
`default_nettype none

`include "pit_config.svh"

module pit_counter_checker (
    input wire logic [`PIT_BYTE_WIDTH-1:0] data_out,
    input wire logic                       counter_out
);

    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_index = 0;
    int test_errors = 0;
    int test_checks = 0;

    task automatic begin_test(input int idx);
        test_index  = idx;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic check_out(input int period, input logic expected);
        test_checks++;
        check_count++;
        if (counter_out !== expected) begin
            $display("[FAIL] test %0d period %0d counter_out: got %h expected %h",
                     test_index, period, counter_out, expected);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic check_data_out(input logic [`PIT_BYTE_WIDTH-1:0] expected);
        test_checks++;
        check_count++;
        if (data_out !== expected) begin
            $display("[FAIL] test %0d data_out: got %h expected %h",
                     test_index, data_out, expected);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d: %s, %0d checks, %0d errors", test_index,
                 (test_errors == 0) ? "ok" : "bad", test_checks, test_errors);
    endtask

    task automatic report_counts();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
    endtask

endmodule

`default_nettype wire

// ==== dv/pit_counter_tb.sv ====
/*
 * Interval timer testbench
 *   clock, reset and watchdog
 *   stimulus table applied in a loop
 *   DUT instance and checker
 */
`default_nettype none

`include "pit_config.svh"

module pit_counter_tb;

    // Row layout: settings, then expected counter_out bits (bit 0 is period 1) and readback
    typedef struct packed {
        logic [2:0]  mode;
        logic [1:0]  rw;
        logic [15:0] preset;
        logic        gate;
        logic [7:0]  periods;
        logic [7:0]  gate_off_at;
        logic [7:0]  gate_off_len;
        logic [7:0]  latch_at;
        logic [15:0] exp_out;
        logic [15:0] exp_read;
        logic [15:0] exp_live;
    } test_row_t;

    localparam int ROWS = 8;

    logic                        clock;
    logic                        reset;
    logic                        address;
    logic                        write;
    logic                        read;
    logic [`PIT_BYTE_WIDTH-1:0]  data_in;
    logic                        counter_clock;
    logic                        counter_gate;
    logic [`PIT_BYTE_WIDTH-1:0]  data_out;
    logic                        counter_out;
    test_row_t                   rows [ROWS];

    pit_counter dut0 (
        .clock         (clock),
        .reset         (reset),
        .address       (address),
        .write         (write),
        .read          (read),
        .data_in       (data_in),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .data_out      (data_out),
        .counter_out   (counter_out)
    );

    pit_counter_checker checker0 (
        .data_out    (data_out),
        .counter_out (counter_out)
    );

    always #5 clock = ~clock;

    task automatic bus_write(input logic addr, input logic [7:0] value);
        @(posedge clock);
        address <= addr;
        data_in <= value;
        write   <= 1'b1;
        @(posedge clock);
        write   <= 1'b0;
        address <= `PIT_ADDR_COUNTER;
    endtask

    // Read one byte from the count register and let the read pointer settle
    task automatic read_byte(input logic [7:0] expected);
        @(posedge clock);
        address <= `PIT_ADDR_COUNTER;
        read    <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        checker0.check_data_out(expected);
        @(posedge clock);
        read <= 1'b0;
        repeat (3) @(posedge clock);
    endtask

    task automatic read_value(input logic [1:0] rw, input logic [15:0] expected);
        if (rw == pit_pkg::RW_MSB_ONLY) begin
            read_byte(expected[15:8]);
        end else if (rw == pit_pkg::RW_LSB_ONLY) begin
            read_byte(expected[7:0]);
        end else begin
            read_byte(expected[7:0]);
            read_byte(expected[15:8]);
        end
    endtask

    // One counter clock period, 4 clocks high then 4 low, sampled at the end
    task automatic run_period(input logic gate, input int period, input logic expected);
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(posedge clock);
        @(posedge clock);
        counter_gate  <= gate;
        counter_clock <= 1'b1;
        repeat (4) @(posedge clock);
        counter_clock <= 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        checker0.check_out(period, expected);
    endtask

    task automatic run_row(input int idx, input test_row_t row);
        logic gate;
        int   p;
        checker0.begin_test(idx);
        bus_write(`PIT_ADDR_CONTROL, {2'b00, row.rw, row.mode, 1'b0});
        @(posedge clock);
        counter_gate <= row.gate;
        if (row.rw == pit_pkg::RW_MSB_ONLY) begin
            bus_write(`PIT_ADDR_COUNTER, row.preset[15:8]);
        end else if (row.rw == pit_pkg::RW_LSB_ONLY) begin
            bus_write(`PIT_ADDR_COUNTER, row.preset[7:0]);
        end else begin
            bus_write(`PIT_ADDR_COUNTER, row.preset[7:0]);
            bus_write(`PIT_ADDR_COUNTER, row.preset[15:8]);
        end
        for (p = 1; p <= int'(row.periods); p++) begin
            gate = row.gate;
            if (row.gate_off_at != 0 && p >= int'(row.gate_off_at) &&
                p < int'(row.gate_off_at) + int'(row.gate_off_len)) begin
                gate = 1'b0;
            end
            run_period(gate, p, row.exp_out[p-1]);
            if (row.latch_at != 0 && p == int'(row.latch_at)) begin
                bus_write(`PIT_ADDR_CONTROL, 8'h00);
            end
        end
        read_value(row.rw, row.exp_read);
        if (row.latch_at != 0) begin
            read_value(row.rw, row.exp_live);
        end
        checker0.end_test();
    endtask

    initial begin
        int total;
        int i;
        void'($urandom(89));
        clock         = 1'b0;
        reset         = 1'b1;
        address       = `PIT_ADDR_COUNTER;
        write         = 1'b0;
        read          = 1'b0;
        data_in       = '0;
        counter_clock = 1'b0;
        counter_gate  = 1'b0;

        // mode rw preset gate periods off_at off_len latch out read live
        rows[0] = '{3'd0, 2'd2, 16'h0037, 1'b0, 8'd3, 8'd0, 8'd0, 8'd0,
                    16'h0000, 16'h0037, 16'h0000};
        rows[1] = '{3'd0, 2'd1, 16'hA500, 1'b0, 8'd3, 8'd0, 8'd0, 8'd0,
                    16'h0000, 16'hA500, 16'h0000};
        rows[2] = '{3'd0, 2'd3, 16'h1234, 1'b0, 8'd3, 8'd0, 8'd0, 8'd0,
                    16'h0000, 16'h1234, 16'h0000};
        rows[3] = '{3'd0, 2'd3, 16'h0003, 1'b1, 8'd6, 8'd0, 8'd0, 8'd0,
                    16'h0038, 16'h0000, 16'h0000};
        rows[4] = '{3'd0, 2'd3, 16'h0003, 1'b1, 8'd8, 8'd2, 8'd2, 8'd0,
                    16'h00E0, 16'h0000, 16'h0000};
        rows[5] = '{3'd2, 2'd3, 16'h0004, 1'b1, 8'd10, 8'd0, 8'd0, 8'd0,
                    16'h0377, 16'h0003, 16'h0000};
        rows[6] = '{3'd6, 2'd3, 16'h0002, 1'b1, 8'd8, 8'd3, 8'd3, 8'd0,
                    16'h00BD, 16'h0002, 16'h0000};
        rows[7] = '{3'd0, 2'd3, 16'h0010, 1'b1, 8'd7, 8'd0, 8'd0, 8'd4,
                    16'h0000, 16'h000D, 16'h000A};

        total = 0;
        for (i = 0; i < ROWS; i++) begin
            total += int'(rows[i].periods);
        end

        // Watchdog, up to 16 clocks per period with gaps and bus traffic margin
        fork
            begin
                repeat ((total + 8 * ROWS + 64) * 16) @(posedge clock);
                $display("Timeout: the tests did not finish in time");
                $display("*** FAILED ***");
                $finish;
            end
        join_none

        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checker0.begin_test(-1);
        checker0.check_out(0, 1'b0);
        checker0.end_test();

        for (i = 0; i < ROWS; i++) begin
            run_row(i, rows[i]);
        end

        checker0.report_counts();
        if (checker0.error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/pit_pkg.sv
hdl/pit_control_word.sv
hdl/pit_count_core.sv
hdl/pit_read_latch.sv
hdl/pit_counter.sv
dv/pit_counter_sva.sv
dv/pit_counter_checker.sv
dv/pit_counter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pit_counter_tb
RTL_TOP   ?= pit_counter
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
